/* bench/dma_backend_asserts.sv */
// DMA backend bus assertions
// page and length limits, write burst framing, quiet reset
`default_nettype none

module dma_backend_asserts (
    input logic                  clk_i,
    input logic                  rst_ni,
    input dma_pkg::dma_bus_req_t bus_o,
    input dma_pkg::dma_bus_rsp_t bus_i,
    input logic                  trans_complete_o
);

    // byte offset one past each burst, inside the page of its start
    logic [12:0] ar_end;
    logic [12:0] aw_end;
    logic [7:0]  lens [8];
    logic [2:0]  wr_q;
    logic [2:0]  rd_q;
    logic [7:0]  beat_q;
    logic        aw_fire;
    logic        w_fire;

    assign ar_end  = {1'b0, bus_o.ar_addr[11:0]} + {3'b0, bus_o.ar_len, 2'b00} + 13'd4;
    assign aw_end  = {1'b0, bus_o.aw_addr[11:0]} + {3'b0, bus_o.aw_len, 2'b00} + 13'd4;
    assign aw_fire = bus_o.aw_valid & bus_i.aw_ready;
    assign w_fire  = bus_o.w_valid & bus_i.w_ready;

    // --------------------
    // AW lengths in order, beat count in the open write burst
    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            lens[wr_q] <= bus_o.aw_len;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_q   <= '0;
            rd_q   <= '0;
            beat_q <= '0;
        end else begin
            if (aw_fire) begin
                wr_q <= wr_q + 3'd1;
            end
            if (w_fire) begin
                if (beat_q == lens[rd_q]) begin
                    beat_q <= '0;
                    rd_q   <= rd_q + 3'd1;
                end else begin
                    beat_q <= beat_q + 8'd1;
                end
            end
        end
    end

    ar_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_o.ar_valid |-> ar_end <= 13'h1000)
        else $error("read burst crosses a 4 KiB page");

    aw_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_o.aw_valid |-> aw_end <= 13'h1000)
        else $error("write burst crosses a 4 KiB page");

    w_frame: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_fire |-> (wr_q != rd_q) && (bus_o.w_last == (beat_q == lens[rd_q])))
        else $error("w_last does not match the write burst length");

    // quiet in reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clk_i)
        (!rst_ni || $past(!rst_ni)) |-> !(bus_o.ar_valid || bus_o.aw_valid ||
                                          bus_o.w_valid || trans_complete_o))
        else $error("bus activity during or right after reset");

endmodule

bind dma_backend dma_backend_asserts i_dma_backend_asserts (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_o            (bus_o),
    .bus_i            (bus_i),
    .trans_complete_o (trans_complete_o)
);

`default_nettype wire

/* bench/dma_backend_tb.sv */
// DMA backend testbench
// memory-model slave with random stalls, request stimulus and data checks
`default_nettype none

`include "dma_defines.svh"

module dma_backend_tb;

    localparam int n_max   = 16;
    localparam int wait_to = 40000;

    logic                  clk_i;
    logic                  rst_ni;
    dma_pkg::dma_req_t     req_i;
    logic                  req_valid_i;
    logic                  req_ready_o;
    dma_pkg::dma_bus_req_t bus_o;
    dma_pkg::dma_bus_rsp_t bus_i;
    logic                  trans_complete_o;
    logic                  idle_o;

    integer seed = 61;

    // word addressed memory
    // unwritten words come from the fill pattern
    logic [31:0] mem [logic [29:0]];

    // nonzero requests in issue order
    logic [29:0] exp_src [n_max];
    logic [29:0] exp_dst [n_max];
    logic [29:0] exp_words [n_max];
    logic        exp_ser [n_max];
    int          n_req = 0;
    int          done_cnt = 0;
    logic        saw_full = 1'b0;

    // slave bookkeeping
    logic [29:0] ar_addr_q [$];
    logic [8:0]  ar_beats_q [$];
    logic [29:0] aw_addr_q [$];
    logic [29:0] r_addr = '0;
    int          r_left = 0;
    logic [29:0] w_addr = '0;
    logic        w_open = 1'b0;
    int          b_pend = 0;

    dma_backend i_dma_backend (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .bus_o            (bus_o),
        .bus_i            (bus_i),
        .trans_complete_o (trans_complete_o),
        .idle_o           (idle_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // --------------------
    // helpers
    // pattern mixes every address bit
    function automatic logic [31:0] fill_word(input logic [29:0] a);
        return {2'b10, a} ^ {a[14:0], a[29:13]};
    endfunction

    function automatic logic [31:0] read_word(input logic [29:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    // zero-byte source region, request id and the serialize rule
    // request k carries id k+1
    task automatic check_ar(input logic [29:0] a, input logic [3:0] id);
        assert (!(a >= 30'h003C_0000 && a < 30'h003C_0100))
            else fail_now("AR handshake hit the source of a zero-byte request");
        for (int j = 0; j < n_req; j++) begin
            if (a >= exp_src[j] && a < exp_src[j] + exp_words[j]) begin
                assert (id == 4'(j + 1))
                    else fail_now($sformatf("FAIL ar_id: got 0x%0h expected 0x%0h",
                                            id, 4'(j + 1)));
                if (j > 0) begin
                    assert (!(exp_ser[j-1] && done_cnt < j))
                        else fail_now("AR came before the serialized predecessor completed");
                end
            end
        end
    endtask

    // write burst lands in one destination and carries that request's id
    task automatic match_aw_id(input logic [29:0] a, input logic [3:0] id);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < n_req; j++) begin
            if (a >= exp_dst[j] && a < exp_dst[j] + exp_words[j]) begin
                hit = 1'b1;
                assert (id == 4'(j + 1))
                    else fail_now($sformatf("FAIL aw_id: got 0x%0h expected 0x%0h",
                                            id, 4'(j + 1)));
            end
        end
        assert (hit)
            else fail_now("write burst outside every destination range");
    endtask

    // destination must equal the source pattern word by word
    task automatic check_done();
        logic [31:0] got;
        logic [31:0] want;
        assert (done_cnt < n_req)
            else fail_now("completion pulse without a pending request");
        for (int k = 0; k < int'(exp_words[done_cnt]); k++) begin
            got  = read_word(exp_dst[done_cnt] + 30'(k));
            want = fill_word(exp_src[done_cnt] + 30'(k));
            assert (got == want)
                else fail_now($sformatf("FAIL w_data at 0x%08h: got 0x%08h expected 0x%08h",
                                        {exp_dst[done_cnt] + 30'(k), 2'b00}, got, want));
        end
        done_cnt++;
    endtask

    // --------------------
    // slave and monitor
    // handshakes sampled at the falling edge
    // inputs driven after the rise
    initial begin : slave
        logic ar_f;
        logic aw_f;
        logic r_f;
        logic w_f;
        logic b_f;
        bus_i = '0;
        forever begin
            @(negedge clk_i);
            ar_f = bus_o.ar_valid & bus_i.ar_ready;
            aw_f = bus_o.aw_valid & bus_i.aw_ready;
            r_f  = bus_i.r_valid & bus_o.r_ready;
            w_f  = bus_o.w_valid & bus_i.w_ready;
            b_f  = bus_i.b_valid & bus_o.b_ready;
            if (rst_ni && !req_ready_o) begin
                saw_full = 1'b1;
            end
            if (trans_complete_o) begin
                check_done();
            end
            if (ar_f) begin
                check_ar(bus_o.ar_addr[31:2], bus_o.ar_id);
                ar_addr_q.push_back(bus_o.ar_addr[31:2]);
                ar_beats_q.push_back({1'b0, bus_o.ar_len} + 9'd1);
            end
            if (aw_f) begin
                match_aw_id(bus_o.aw_addr[31:2], bus_o.aw_id);
                aw_addr_q.push_back(bus_o.aw_addr[31:2]);
            end
            if (r_f) begin
                r_left--;
                r_addr = r_addr + 30'd1;
            end
            if (w_f) begin
                if (!w_open) begin
                    assert (aw_addr_q.size() > 0)
                        else fail_now("write beat without a write address");
                    w_addr = aw_addr_q.pop_front();
                    w_open = 1'b1;
                end
                mem[w_addr] = bus_o.w_data;
                w_addr = w_addr + 30'd1;
                if (bus_o.w_last) begin
                    w_open = 1'b0;
                    b_pend++;
                end
            end
            if (b_f) begin
                b_pend--;
            end
            @(posedge clk_i);
            #10;
            if (r_left == 0 && ar_addr_q.size() > 0) begin
                r_addr = ar_addr_q.pop_front();
                r_left = int'(ar_beats_q.pop_front());
            end
            // valids hold until their handshake
            if (!(bus_i.r_valid && !r_f)) begin
                bus_i.r_valid = (r_left > 0) && (($random(seed) & 3) != 0);
            end
            bus_i.r_data = read_word(r_addr);
            bus_i.r_last = (r_left == 1);
            if (!(bus_i.b_valid && !b_f)) begin
                bus_i.b_valid = (b_pend > 0) && (($random(seed) & 3) != 0);
            end
            bus_i.ar_ready = (($random(seed) & 3) != 0);
            bus_i.aw_ready = (($random(seed) & 3) != 0);
            bus_i.w_ready  = (($random(seed) & 7) != 0);
        end
    end

    // --------------------
    // stimulus
    task automatic send_req(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] bytes, input logic ser);
        int cnt;
        cnt = 0;
        if (bytes[31:2] != '0) begin
            exp_src[n_req]   = src[31:2];
            exp_dst[n_req]   = dst[31:2];
            exp_words[n_req] = bytes[31:2];
            exp_ser[n_req]   = ser;
            n_req++;
        end
        req_i       = '{id: 4'(n_req), src: src, dst: dst, num_bytes: bytes, serialize: ser};
        req_valid_i = 1'b1;
        forever begin
            @(negedge clk_i);
            if (req_ready_o) begin
                break;
            end
            cnt++;
            if (cnt > wait_to) begin
                fail_now("timeout waiting for req_ready_o");
            end
        end
        @(posedge clk_i);
        #10;
        req_valid_i = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] r_off [4];
        logic [31:0] r_len [4];
        int          cnt;
        req_i       = '0;
        req_valid_i = 1'b0;
        rst_ni      = 1'b0;
        // offsets and sizes of the random requests
        for (int i = 0; i < 4; i++) begin
            r_off[i] = $random(seed);
            r_len[i] = $random(seed);
        end
        repeat (16) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        // source page crossing
        // held by serialize
        send_req(32'h0001_0F00, 32'h0008_0000, 32'd1024, 1'b1);
        // destination page crossing
        send_req(32'h0001_2000, 32'h0008_2E00, 32'd1024, 1'b0);
        // longer than 1 KiB
        // several capped bursts
        send_req(32'h0001_4000, 32'h0008_5000, 32'd3000, 1'b1);
        send_req(32'h00F0_0000, 32'h0008_F000, 32'd0, 1'b0);
        send_req(32'h0001_8080, 32'h0008_8040, 32'd64, 1'b0);
        send_req(32'h0001_9000, 32'h0008_9000, 32'd8, 1'b1);
        send_req(32'h0001_A7FC, 32'h0008_A804, 32'd40, 1'b0);
        // random offsets and sizes
        for (int i = 0; i < 4; i++) begin
            send_req(32'h0002_0000 + 32'(i) * 32'h2000 + {20'b0, r_off[i][11:2], 2'b00},
                     32'h0009_0000 + 32'(i) * 32'h2000 + {20'b0, r_off[i][21:12], 2'b00},
                     {21'b0, r_len[i][10:2], 2'b00} + 32'd4, r_len[i][16]);
        end
        cnt = 0;
        while (done_cnt < n_req || !idle_o) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > wait_to) begin
                fail_now("timeout waiting for all transfers to complete");
            end
        end
        repeat (20) @(negedge clk_i);
        assert (done_cnt == n_req)
            else fail_now($sformatf("FAIL trans_complete_o count: got 0x%0h expected 0x%0h",
                                    done_cnt, n_req));
        assert (idle_o)
            else fail_now("FAIL idle_o: got 0x0 expected 0x1");
        assert (saw_full)
            else fail_now("req_ready_o never went low with four requests waiting");
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* design/dma_backend.sv */
// DMA backend top level
// request FIFO, burst reshaper and data mover in a pipeline
`default_nettype none

`include "dma_defines.svh"

module dma_backend (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dma_pkg::dma_req_t     req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output dma_pkg::dma_bus_req_t bus_o,
    input  dma_pkg::dma_bus_rsp_t bus_i,
    output logic                  trans_complete_o,
    output logic                  idle_o
);

    dma_pkg::dma_req_t   fifo_req;
    logic                fifo_full;
    logic                fifo_empty;
    logic                rs_take;
    logic                rs_idle;
    dma_pkg::dma_burst_t burst;
    logic                burst_valid;
    logic                burst_ready;
    logic                done;
    logic                dm_idle;

    // --------------------
    // request FIFO
    // accepts whenever not full
    assign req_ready_o = ~fifo_full;

    dma_fifo #(
        .elem_t (dma_pkg::dma_req_t),
        .depth  (`DMA_REQ_DEPTH)
    ) i_req_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (req_valid_i),
        .data_i  (req_i),
        .full_o  (fifo_full),
        .pop_i   (rs_take),
        .data_o  (fifo_req),
        .empty_o (fifo_empty)
    );

    // --------------------
    // reshaper
    dma_burst_reshaper i_burst_reshaper (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (fifo_req),
        .req_valid_i   (~fifo_empty),
        .req_ready_o   (rs_take),
        .burst_o       (burst),
        .burst_valid_o (burst_valid),
        .burst_ready_i (burst_ready),
        .done_i        (done),
        .idle_o        (rs_idle)
    );

    // --------------------
    // data mover
    dma_data_mover i_data_mover (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .burst_i       (burst),
        .burst_valid_i (burst_valid),
        .burst_ready_o (burst_ready),
        .bus_o         (bus_o),
        .bus_i         (bus_i),
        .done_o        (done),
        .idle_o        (dm_idle)
    );

    assign trans_complete_o = done;

    // nothing queued, nothing being split, nothing on the bus
    assign idle_o = fifo_empty & rs_idle & dm_idle;

endmodule

`default_nettype wire

/* design/dma_burst_reshaper.sv */
// burst reshaper
// cuts 1D requests into bursts that stay inside a 4 KiB page on both
// sides and never exceed 256 beats, and holds the next request after
// a serialized one until its completion comes back
`default_nettype none

`include "dma_defines.svh"

module dma_burst_reshaper (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  dma_pkg::dma_req_t   req_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    output dma_pkg::dma_burst_t burst_o,
    output logic                burst_valid_o,
    input  logic                burst_ready_i,
    input  logic                done_i,
    output logic                idle_o
);

    // word counts, addresses without the byte offset
    localparam int unsigned word_w = `DMA_ADDR_W - `DMA_OFFS_W;
    localparam int unsigned pg_w   = `DMA_PAGE_W - `DMA_OFFS_W;
    localparam int unsigned pend_w = 8;
    localparam logic [word_w-1:0] max_beats = word_w'(1 << `DMA_LEN_W);

    dma_pkg::reshaper_state_e state_q;
    dma_pkg::reshaper_state_e state_d;

    // current request
    logic [`DMA_ID_W-1:0]   id_q;
    logic [`DMA_ADDR_W-1:0] src_q;
    logic [`DMA_ADDR_W-1:0] dst_q;
    logic [word_w-1:0]      words_q;
    logic                   ser_q;

    // requests whose last burst left but whose completion is still due
    logic [pend_w-1:0] pend_q;

    logic [word_w-1:0]      req_words;
    logic                   take;
    logic                   burst_fire;
    logic                   last_fire;
    logic [pg_w:0]          src_to_pb;
    logic [pg_w:0]          dst_to_pb;
    logic [word_w-1:0]      beats;
    logic [word_w-1:0]      beats_m1;
    logic [`DMA_ADDR_W-1:0] step;
    logic                   is_last;

    // --------------------
    // handshakes
    assign req_ready_o   = (state_q == dma_pkg::IDLE);
    assign idle_o        = (state_q == dma_pkg::IDLE);
    assign burst_valid_o = (state_q == dma_pkg::SPLIT);

    assign take       = req_valid_i & req_ready_o;
    assign burst_fire = burst_valid_o & burst_ready_i;
    assign last_fire  = burst_fire & is_last;

    // sub-word bytes do not count
    assign req_words = req_i.num_bytes[`DMA_ADDR_W-1:`DMA_OFFS_W];

    // --------------------
    // burst size
    // words left before each page boundary, 1 up to a full page
    assign src_to_pb = {1'b1, {pg_w{1'b0}}} - {1'b0, src_q[`DMA_PAGE_W-1:`DMA_OFFS_W]};
    assign dst_to_pb = {1'b1, {pg_w{1'b0}}} - {1'b0, dst_q[`DMA_PAGE_W-1:`DMA_OFFS_W]};

    // smallest of remaining, both page limits and the length cap
    always_comb begin
        beats = words_q;
        if (word_w'(src_to_pb) < beats) begin
            beats = word_w'(src_to_pb);
        end
        if (word_w'(dst_to_pb) < beats) begin
            beats = word_w'(dst_to_pb);
        end
        if (max_beats < beats) begin
            beats = max_beats;
        end
    end

    assign beats_m1 = beats - 1'b1;
    assign is_last  = (beats == words_q);
    // bytes consumed by this burst
    assign step     = {beats, {`DMA_OFFS_W{1'b0}}};

    // burst held from registers, stable under back-pressure
    assign burst_o.id          = id_q;
    assign burst_o.src         = src_q;
    assign burst_o.dst         = dst_q;
    assign burst_o.len         = beats_m1[`DMA_LEN_W-1:0];
    assign burst_o.last_of_req = is_last;

    // --------------------
    // FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::IDLE: begin
                // zero-byte requests are popped and dropped here
                if (take && (req_words != '0)) begin
                    state_d = dma_pkg::SPLIT;
                end
            end
            dma_pkg::SPLIT: begin
                if (last_fire) begin
                    state_d = ser_q ? dma_pkg::WAIT_DONE : dma_pkg::IDLE;
                end
            end
            dma_pkg::WAIT_DONE: begin
                // completions arrive in order, ours is the newest one
                if (done_i && (pend_q == pend_w'(1))) begin
                    state_d = dma_pkg::IDLE;
                end
            end
            default: state_d = dma_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= dma_pkg::IDLE;
            pend_q  <= '0;
        end else begin
            state_q <= state_d;
            case ({last_fire, done_i})
                2'b10:   pend_q <= pend_q + 1'b1;
                2'b01:   pend_q <= pend_q - 1'b1;
                default: pend_q <= pend_q;
            endcase
        end
    end

    // request registers, word aligned
    always_ff @(posedge clk_i) begin
        if (take) begin
            id_q    <= req_i.id;
            src_q   <= {req_i.src[`DMA_ADDR_W-1:`DMA_OFFS_W], {`DMA_OFFS_W{1'b0}}};
            dst_q   <= {req_i.dst[`DMA_ADDR_W-1:`DMA_OFFS_W], {`DMA_OFFS_W{1'b0}}};
            words_q <= req_words;
            ser_q   <= req_i.serialize;
        end else if (burst_fire) begin
            src_q   <= src_q + step;
            dst_q   <= dst_q + step;
            words_q <= words_q - beats;
        end
    end

endmodule

`default_nettype wire

/* design/dma_data_mover.sv */
// data mover
// issues one read and one write burst per descriptor, passes R beats
// through a small buffer to W, frames write bursts and turns write
// responses into a completion strobe
`default_nettype none

`include "dma_defines.svh"

module dma_data_mover (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  dma_pkg::dma_burst_t   burst_i,
    input  logic                  burst_valid_i,
    output logic                  burst_ready_o,
    output dma_pkg::dma_bus_req_t bus_o,
    input  dma_pkg::dma_bus_rsp_t bus_i,
    output logic                  done_o,
    output logic                  idle_o
);

    // bursts accepted but not yet answered by B
    localparam int unsigned out_w = 16;

    dma_pkg::dma_burst_t    ar_head;
    dma_pkg::dma_burst_t    aw_head;
    logic [`DMA_LEN_W-1:0]  wlen_head;
    logic [`DMA_DATA_W-1:0] buf_head;
    logic                   blast_head;

    logic ar_full;
    logic ar_empty;
    logic aw_full;
    logic aw_empty;
    logic wlen_full;
    logic wlen_empty;
    logic blast_full;
    logic blast_empty;
    logic buf_full;
    logic buf_empty;

    logic burst_fire;
    logic ar_fire;
    logic aw_valid;
    logic aw_fire;
    logic r_fire;
    logic w_valid;
    logic w_last;
    logic w_fire;
    logic b_fire;

    logic [`DMA_LEN_W-1:0] beat_q;
    logic [out_w-1:0]      out_q;
    logic                  done_q;

    // --------------------
    // descriptor intake
    // same descriptor goes to both address queues
    assign burst_ready_o = ~ar_full & ~aw_full;
    assign burst_fire    = burst_valid_i & burst_ready_o;

    dma_fifo #(
        .elem_t (dma_pkg::dma_burst_t),
        .depth  (`DMA_AX_DEPTH)
    ) i_ar_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (burst_fire),
        .data_i  (burst_i),
        .full_o  (ar_full),
        .pop_i   (ar_fire),
        .data_o  (ar_head),
        .empty_o (ar_empty)
    );

    dma_fifo #(
        .elem_t (dma_pkg::dma_burst_t),
        .depth  (`DMA_AX_DEPTH)
    ) i_aw_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (burst_fire),
        .data_i  (burst_i),
        .full_o  (aw_full),
        .pop_i   (aw_fire),
        .data_o  (aw_head),
        .empty_o (aw_empty)
    );

    // --------------------
    // address channels
    assign ar_fire = ~ar_empty & bus_i.ar_ready;

    // AW waits for room to record its W framing and B tag
    assign aw_valid = ~aw_empty & ~wlen_full & ~blast_full;
    assign aw_fire  = aw_valid & bus_i.aw_ready;

    assign bus_o.ar_valid = ~ar_empty;
    assign bus_o.ar_id    = ar_head.id;
    assign bus_o.ar_addr  = ar_head.src;
    assign bus_o.ar_len   = ar_head.len;
    assign bus_o.aw_valid = aw_valid;
    assign bus_o.aw_id    = aw_head.id;
    assign bus_o.aw_addr  = aw_head.dst;
    assign bus_o.aw_len   = aw_head.len;

    // write burst lengths in AW order
    dma_fifo #(
        .elem_t (logic [`DMA_LEN_W-1:0]),
        .depth  (`DMA_AX_DEPTH)
    ) i_wlen_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (aw_fire),
        .data_i  (aw_head.len),
        .full_o  (wlen_full),
        .pop_i   (w_fire & w_last),
        .data_o  (wlen_head),
        .empty_o (wlen_empty)
    );

    // last-of-request tag per outstanding write burst
    dma_fifo #(
        .elem_t (logic),
        .depth  (`DMA_AX_DEPTH)
    ) i_blast_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (aw_fire),
        .data_i  (aw_head.last_of_req),
        .full_o  (blast_full),
        .pop_i   (b_fire),
        .data_o  (blast_head),
        .empty_o (blast_empty)
    );

    // --------------------
    // data path
    // R stalls while the buffer is full
    assign r_fire = bus_i.r_valid & ~buf_full;

    dma_fifo #(
        .elem_t (logic [`DMA_DATA_W-1:0]),
        .depth  (`DMA_BUF_DEPTH)
    ) i_beat_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (r_fire),
        .data_i  (bus_i.r_data),
        .full_o  (buf_full),
        .pop_i   (w_fire),
        .data_o  (buf_head),
        .empty_o (buf_empty)
    );

    // W only after its AW went out
    assign w_valid = ~buf_empty & ~wlen_empty;
    assign w_last  = (beat_q == wlen_head);
    assign w_fire  = w_valid & bus_i.w_ready;

    assign bus_o.w_valid = w_valid;
    assign bus_o.w_data  = buf_head;
    assign bus_o.w_last  = w_last;
    assign bus_o.r_ready = ~buf_full;
    assign bus_o.b_ready = 1'b1;

    // B is always accepted
    assign b_fire = bus_i.b_valid;

    // --------------------
    // counters and completion
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
            out_q  <= '0;
            done_q <= 1'b0;
        end else begin
            // beat position inside the current write burst
            if (w_fire) begin
                beat_q <= w_last ? '0 : beat_q + 1'b1;
            end
            case ({burst_fire, b_fire})
                2'b10:   out_q <= out_q + 1'b1;
                2'b01:   out_q <= out_q - 1'b1;
                default: out_q <= out_q;
            endcase
            // one cycle after the B of a request's final burst
            done_q <= b_fire & ~blast_empty & blast_head;
        end
    end

    assign done_o = done_q;
    assign idle_o = (out_q == '0) & ~done_q;

endmodule

`default_nettype wire

/* design/dma_fifo.sv */
// generic synchronous FIFO
// circular buffer with fill count, any element type
// push and pop may happen in the same cycle
`default_nettype none

module dma_fifo #(
    parameter type         elem_t = logic,
    parameter int unsigned depth  = 2
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  push_i,
    input  elem_t data_i,
    output logic  full_o,
    input  logic  pop_i,
    output elem_t data_o,
    output logic  empty_o
);

    localparam int unsigned ptr_w = $clog2(depth);
    localparam int unsigned cnt_w = $clog2(depth + 1);

    elem_t            mem_q [depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] cnt_q;
    logic             push;
    logic             pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (cnt_q == cnt_w'(depth));
    assign empty_o = (cnt_q == '0);

    // overflow and underflow requests are dropped
    assign push = push_i & ~full_o;
    assign pop  = pop_i & ~empty_o;

    // head of queue, valid while not empty
    assign data_o = mem_q[rd_ptr_q];

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // pointers and fill count
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dma_pkg.sv */
// DMA backend types
// request, burst descriptor, master bus and reshaper states
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

    // --------------------
    // 1D transfer request
    // low address and byte count bits are ignored
    typedef struct packed {
        logic [`DMA_ID_W-1:0]   id;
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        logic [`DMA_ADDR_W-1:0] num_bytes;
        // hold the next request until this one completes
        logic                   serialize;
    } dma_req_t;

    // one page-safe burst, read and write side share it
    typedef struct packed {
        logic [`DMA_ID_W-1:0]   id;
        logic [`DMA_ADDR_W-1:0] src;
        logic [`DMA_ADDR_W-1:0] dst;
        // beats minus one
        logic [`DMA_LEN_W-1:0]  len;
        // final burst of its request
        logic                   last_of_req;
    } dma_burst_t;

    // --------------------
    // master side of the bus
    // incrementing, full width bursts only
    typedef struct packed {
        logic                   ar_valid;
        logic [`DMA_ID_W-1:0]   ar_id;
        logic [`DMA_ADDR_W-1:0] ar_addr;
        logic [`DMA_LEN_W-1:0]  ar_len;
        logic                   aw_valid;
        logic [`DMA_ID_W-1:0]   aw_id;
        logic [`DMA_ADDR_W-1:0] aw_addr;
        logic [`DMA_LEN_W-1:0]  aw_len;
        logic                   w_valid;
        logic [`DMA_DATA_W-1:0] w_data;
        logic                   w_last;
        logic                   r_ready;
        logic                   b_ready;
    } dma_bus_req_t;

    // slave side of the bus
    typedef struct packed {
        logic                   ar_ready;
        logic                   aw_ready;
        logic                   w_ready;
        logic                   r_valid;
        logic [`DMA_DATA_W-1:0] r_data;
        logic                   r_last;
        logic                   b_valid;
    } dma_bus_rsp_t;

    // reshaper FSM
    typedef enum logic [1:0] {
        IDLE,
        SPLIT,
        WAIT_DONE
    } reshaper_state_e;

endpackage

`default_nettype wire

/* include/dma_defines.svh */
// DMA backend parameters
// bus widths, page geometry, burst limit and queue depths
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// bus geometry
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_STRB_W 4
`define DMA_OFFS_W 2
`define DMA_ID_W   4

// burst length field, len is beats minus one
`define DMA_LEN_W  8

// 4 KiB pages
`define DMA_PAGE_W 12

// --------------------
// queue depths
`define DMA_REQ_DEPTH 4
`define DMA_AX_DEPTH  4
`define DMA_BUF_DEPTH 4

`endif

/* list.f */
+incdir+include
design/dma_pkg.sv
design/dma_fifo.sv
design/dma_burst_reshaper.sv
design/dma_data_mover.sv
design/dma_backend.sv
bench/dma_backend_asserts.sv
bench/dma_backend_tb.sv

/* run.sh */
#!/bin/sh
# build and run the DMA backend simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    -f list.f \
    --top-module dma_backend_tb \
    -o sim_dma_backend
./obj_dir/sim_dma_backend
